/* sources.f */
mcu_pkg.sv
sram_bank.sv
memory_subsystem.sv
system_bus.sv
ao_peripheral_subsystem.sv
core_v_mini_mcu.sv
core_v_mini_mcu_assertions.sv
tb_core_v_mini_mcu.sv

/* Bender.yml */
package:
  name: core_v_mini_mcu

sources:
  - mcu_pkg.sv
  - sram_bank.sv
  - memory_subsystem.sv
  - system_bus.sv
  - ao_peripheral_subsystem.sv
  - core_v_mini_mcu.sv
  - target: test
    files:
      - core_v_mini_mcu_assertions.sv
      - tb_core_v_mini_mcu.sv

/* tb_core_v_mini_mcu.sv */
/*
 * Testbench with default DUT parameters and a shadow model of RAM and AO registers.
 * GPIO_IN and INTR_STATUS reads assume gpio_i has been stable for several cycles.
 */
module tb_core_v_mini_mcu
  import mcu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NUM_BANKS   = 2;
  localparam int unsigned BANK_WORDS  = 256;
  localparam int unsigned NUM_GPIO    = 8;
  localparam int unsigned RAM_WORDS   = NUM_BANKS * BANK_WORDS;
  localparam addr_t       RAM_SIZE    = addr_t'(RAM_WORDS * 4);
  localparam data_t       GPIO_MASK   = data_t'((64'd1 << NUM_GPIO) - 1);
  localparam int          CLK_PERIOD  = 20;
  localparam int          GPIO_SETTLE = 5;
  localparam int          NUM_RAM_OPS = 48;
  localparam int          NUM_B2B     = 120;
  // Tests 2 to 5 need fewer than 40 accesses
  localparam int          TOTAL_ACCESSES = 3 * NUM_RAM_OPS + NUM_B2B + 40;

  typedef struct packed {
    logic  exit_valid;
    data_t exit_value;
    data_t gpio_out;
    data_t gpio_oe;
    data_t gpio_in;
    data_t intr_status;
    data_t intr_enable;
  } shadow_regs_t;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  logic                req_ready;
  bus_req_t            bus_req;
  logic                rsp_valid;
  logic                rsp_ready;
  bus_rsp_t            bus_rsp;
  logic [NUM_GPIO-1:0] gpio_in;
  logic [NUM_GPIO-1:0] gpio_out;
  logic [NUM_GPIO-1:0] gpio_oe;
  logic                irq;
  logic                exit_valid;
  data_t               exit_value;

  data_t        shadow_ram [RAM_WORDS];
  bit           ram_init [RAM_WORDS];
  shadow_regs_t regs;
  bus_rsp_t     exp_q [$];
  int           seed = 99;
  string        test_name;
  int           test_num = 0;
  int           test_checks = 0;
  int           test_errors = 0;
  int           check_count = 0;
  int           error_count = 0;
  int           issued_count = 0;
  int           rsp_count = 0;
  bit           rand_ready = 1'b0;

  core_v_mini_mcu #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS),
    .NUM_GPIO  (NUM_GPIO)
  ) u_core_v_mini_mcu (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .bus_req_valid_i(req_valid),
    .bus_req_ready_o(req_ready),
    .bus_req_i      (bus_req),
    .bus_rsp_valid_o(rsp_valid),
    .bus_rsp_ready_i(rsp_ready),
    .bus_rsp_o      (bus_rsp),
    .gpio_i         (gpio_in),
    .gpio_o         (gpio_out),
    .gpio_oe_o      (gpio_oe),
    .irq_o          (irq),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic bus_req_t build_req(addr_t addr, data_t wdata, be_t be, logic we);
    return '{addr: addr, wdata: wdata, be: be, we: we};
  endfunction

  function automatic target_e decode_target(addr_t addr);
    if (addr >= RAM_BASE && addr < RAM_BASE + RAM_SIZE)
      return TGT_RAM;
    if (addr >= AO_BASE && addr < AO_BASE + AO_SIZE)
      return TGT_AO;
    return TGT_NONE;
  endfunction

  // Evaluated at acceptance before the access updates the model
  function automatic bus_rsp_t expected_rsp(bus_req_t req);
    bus_rsp_t rsp_exp;
    addr_t    ofs;
    rsp_exp = '0;
    case (decode_target(req.addr))
      TGT_NONE: rsp_exp.err = 1'b1;
      TGT_RAM: begin
        if (!req.we)
          rsp_exp.rdata = shadow_ram[(req.addr - RAM_BASE) >> 2];
      end
      default: begin
        ofs = (req.addr - AO_BASE) & ~addr_t'(3);
        if (!req.we) begin
          case (ofs)
            EXIT_VALID_OFS:  rsp_exp.rdata = data_t'(regs.exit_valid);
            EXIT_VALUE_OFS:  rsp_exp.rdata = regs.exit_value;
            GPIO_OUT_OFS:    rsp_exp.rdata = regs.gpio_out;
            GPIO_OE_OFS:     rsp_exp.rdata = regs.gpio_oe;
            GPIO_IN_OFS:     rsp_exp.rdata = regs.gpio_in;
            INTR_STATUS_OFS: rsp_exp.rdata = regs.intr_status;
            INTR_ENABLE_OFS: rsp_exp.rdata = regs.intr_enable;
            default:         rsp_exp.rdata = '0;
          endcase
        end
      end
    endcase
    return rsp_exp;
  endfunction

  function automatic void update_model(bus_req_t req);
    int unsigned idx;
    addr_t       ofs;
    if (!req.we)
      return;
    if (decode_target(req.addr) == TGT_RAM) begin
      idx = (req.addr - RAM_BASE) >> 2;
      for (int i = 0; i < 4; i++) begin
        if (req.be[i])
          shadow_ram[idx][8*i +: 8] = req.wdata[8*i +: 8];
      end
      if (req.be == 4'hF)
        ram_init[idx] = 1'b1;
    end else if (decode_target(req.addr) == TGT_AO) begin
      ofs = (req.addr - AO_BASE) & ~addr_t'(3);
      case (ofs)
        EXIT_VALID_OFS:  regs.exit_valid = req.wdata[0];
        EXIT_VALUE_OFS:  regs.exit_value = req.wdata;
        GPIO_OUT_OFS:    regs.gpio_out = req.wdata & GPIO_MASK;
        GPIO_OE_OFS:     regs.gpio_oe = req.wdata & GPIO_MASK;
        INTR_STATUS_OFS: regs.intr_status &= ~req.wdata;
        INTR_ENABLE_OFS: regs.intr_enable = req.wdata & GPIO_MASK;
        default: ;
      endcase
    end
  endfunction

  task automatic check_value(string what, data_t exp, data_t act);
    check_count++;
    assert (act === exp) else begin
      $display("ERROR %s: %s expected %h, actual %h", test_name, what, exp, act);
      error_count++;
    end
  endtask

  // Returns at the edge where the request is accepted
  task automatic send_req(bus_req_t r);
    @(negedge clk);
    req_valid = 1'b1;
    bus_req   = r;
    @(posedge clk);
    while (!req_ready)
      @(posedge clk);
    exp_q.push_back(expected_rsp(r));
    update_model(r);
    issued_count++;
  endtask

  task automatic access(bus_req_t r);
    send_req(r);
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic drive_gpio(data_t value);
    @(negedge clk);
    gpio_in = value[NUM_GPIO-1:0];
    regs.intr_status |= value & GPIO_MASK & ~regs.gpio_in;
    regs.gpio_in = value & GPIO_MASK;
    // Synchronizer and edge detector need three cycles
    repeat (GPIO_SETTLE) @(negedge clk);
  endtask

  task automatic begin_test(string name);
    test_num++;
    test_name   = name;
    test_checks = check_count;
    test_errors = error_count;
  endtask

  task automatic end_test();
    $display("test %0d %s: %0d checks, %0d errors", test_num, test_name,
             check_count - test_checks, error_count - test_errors);
  endtask

  always @(posedge clk) begin
    bus_rsp_t rsp_exp;
    if (rst_n && rsp_valid && rsp_ready) begin
      check_count++;
      rsp_count++;
      assert (exp_q.size() != 0) else begin
        $display("Test %s got a response with no request outstanding", test_name);
        error_count++;
      end
      if (exp_q.size() != 0) begin
        rsp_exp = exp_q.pop_front();
        assert (bus_rsp === rsp_exp) else begin
          $display("ERROR %s: expected %h, actual %h", test_name, rsp_exp, bus_rsp);
          error_count++;
        end
      end
    end
  end

  // Random back-pressure for test 6
  always @(negedge clk) begin
    if (rand_ready)
      rsp_ready = ($random(seed) & 1) != 0;
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_ACCESSES * 40 + 1000));
    $display("Timeout: the tests did not finish in time, test %s was running", test_name);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int unsigned idx;
    data_t       val;
    be_t         be;
    bus_req_t    r;
    int          assert_fails;
    regs      = '0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    bus_req   = '0;
    rsp_ready = 1'b1;
    gpio_in   = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset_and_ram");
    check_value("bus_rsp_valid_o", '0, data_t'(rsp_valid));
    check_value("bus_req_ready_o", 32'd1, data_t'(req_ready));
    check_value("exit_valid_o", '0, data_t'(exit_valid));
    check_value("exit_value_o", '0, exit_value);
    check_value("gpio_o", '0, data_t'(gpio_out));
    check_value("gpio_oe_o", '0, data_t'(gpio_oe));
    check_value("irq_o", '0, data_t'(irq));
    access(build_req(AO_BASE + INTR_STATUS_OFS, '0, 4'hF, 1'b0));
    access(build_req(AO_BASE + INTR_ENABLE_OFS, '0, 4'hF, 1'b0));
    for (int i = 0; i < NUM_RAM_OPS; i++) begin
      // Banks in turn
      idx = (i % NUM_BANKS) * BANK_WORDS + {$random(seed)} % BANK_WORDS;
      val = $random(seed);
      be  = be_t'($random(seed));
      if (!ram_init[idx])
        access(build_req(RAM_BASE + idx * 4, ~val, 4'hF, 1'b1));
      access(build_req(RAM_BASE + idx * 4, val, be, 1'b1));
      access(build_req(RAM_BASE + idx * 4, '0, 4'hF, 1'b0));
    end
    end_test();

    begin_test("address_decode");
    access(build_req(RAM_BASE + RAM_SIZE - 4, $random(seed), 4'hF, 1'b1));
    access(build_req(RAM_BASE + RAM_SIZE - 4, '0, 4'hF, 1'b0));
    access(build_req(RAM_BASE + RAM_SIZE, '0, 4'hF, 1'b0));
    access(build_req(AO_BASE + AO_SIZE - 4, '0, 4'hF, 1'b0));
    access(build_req(AO_BASE + AO_SIZE, '0, 4'hF, 1'b0));
    access(build_req(AO_BASE - 4, '0, 4'hF, 1'b0));
    access(build_req(32'hFFFF_FFFC, '0, 4'hF, 1'b0));
    access(build_req(32'h4000_0000, $random(seed), 4'hF, 1'b1));
    end_test();

    begin_test("gpio");
    val = $random(seed);
    access(build_req(AO_BASE + GPIO_OUT_OFS, val, 4'hF, 1'b1));
    check_value("gpio_o", val & GPIO_MASK, data_t'(gpio_out));
    val = $random(seed);
    access(build_req(AO_BASE + GPIO_OE_OFS, val, 4'hF, 1'b1));
    check_value("gpio_oe_o", val & GPIO_MASK, data_t'(gpio_oe));
    access(build_req(AO_BASE + GPIO_OUT_OFS, '0, 4'hF, 1'b0));
    access(build_req(AO_BASE + GPIO_OE_OFS, '0, 4'hF, 1'b0));
    drive_gpio($random(seed));
    access(build_req(AO_BASE + GPIO_IN_OFS, '0, 4'hF, 1'b0));
    end_test();

    begin_test("gpio_interrupt");
    drive_gpio('0);
    access(build_req(AO_BASE + INTR_STATUS_OFS, GPIO_MASK, 4'hF, 1'b1));
    access(build_req(AO_BASE + INTR_ENABLE_OFS, 32'h0F, 4'hF, 1'b1));
    check_value("irq_o", '0, data_t'(irq));
    // Edges on disabled inputs only
    drive_gpio(32'h30);
    access(build_req(AO_BASE + INTR_STATUS_OFS, '0, 4'hF, 1'b0));
    check_value("irq_o", '0, data_t'(irq));
    drive_gpio(32'h31);
    access(build_req(AO_BASE + INTR_STATUS_OFS, '0, 4'hF, 1'b0));
    check_value("irq_o", 32'd1, data_t'(irq));
    access(build_req(AO_BASE + INTR_STATUS_OFS, 32'h01, 4'hF, 1'b1));
    check_value("irq_o", '0, data_t'(irq));
    access(build_req(AO_BASE + INTR_STATUS_OFS, '0, 4'hF, 1'b0));
    access(build_req(AO_BASE + INTR_STATUS_OFS, 32'h30, 4'hF, 1'b1));
    access(build_req(AO_BASE + INTR_STATUS_OFS, '0, 4'hF, 1'b0));
    end_test();

    begin_test("exit");
    val = $random(seed);
    access(build_req(AO_BASE + EXIT_VALUE_OFS, val, 4'hF, 1'b1));
    check_value("exit_value_o", val, exit_value);
    access(build_req(AO_BASE + EXIT_VALID_OFS, 32'h3, 4'hF, 1'b1));
    check_value("exit_valid_o", 32'd1, data_t'(exit_valid));
    access(build_req(AO_BASE + EXIT_VALUE_OFS, '0, 4'hF, 1'b0));
    access(build_req(AO_BASE + EXIT_VALID_OFS, '0, 4'hF, 1'b0));
    end_test();

    begin_test("back_to_back");
    @(posedge clk);
    rand_ready = 1'b1;
    for (int i = 0; i < NUM_B2B; i++) begin
      idx = {$random(seed)} % RAM_WORDS;
      val = $random(seed);
      case (val[1:0])
        2'd0: r = build_req(RAM_BASE + idx * 4, val, 4'hF, 1'b1);
        // Unwritten words get written first
        2'd1: r = build_req(RAM_BASE + idx * 4, val, 4'hF, !ram_init[idx]);
        2'd2: r = build_req(AO_BASE + EXIT_VALUE_OFS, val, 4'hF, val[31]);
        default: r = build_req(32'h3000_0000 + idx * 4, '0, 4'hF, 1'b0);
      endcase
      send_req(r);
    end
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    rand_ready = 1'b0;
    @(negedge clk);
    rsp_ready = 1'b1;
    check_value("response count", data_t'(issued_count), data_t'(rsp_count));
    end_test();

    assert_fails = u_core_v_mini_mcu.u_system_bus.u_core_v_mini_mcu_assertions.fail_count;
    $display("%0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* core_v_mini_mcu_assertions.sv */
/*
 * Handshake and reset checks bound to every system_bus instance.
 * The stability check relies on slaves holding read data until their next strobe.
 */
module core_v_mini_mcu_assertions
  import mcu_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     rsp_valid_i,
  input logic     rsp_ready_i,
  input bus_rsp_t rsp_i,
  input logic     mem_req_i,
  input logic     ao_req_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Held response keeps its value until taken
  rsp_held_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
  else begin
    $error("held response changed or vanished before it was taken");
    fail_count++;
  end

  no_strobe_when_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |-> !mem_req_i && !ao_req_i)
  else begin
    $error("slave strobe issued while a response was blocked");
    fail_count++;
  end

  rsp_idle_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !rsp_valid_i)
  else begin
    $error("response valid in the cycle after reset");
    fail_count++;
  end

endmodule

bind system_bus core_v_mini_mcu_assertions u_core_v_mini_mcu_assertions (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .rsp_valid_i(bus_rsp_valid_o),
  .rsp_ready_i(bus_rsp_ready_i),
  .rsp_i      (bus_rsp_o),
  .mem_req_i  (mem_req_o),
  .ao_req_i   (ao_req_o)
);

/* core_v_mini_mcu.sv */
/*
 * MCU core driven by one external bus master, with banked RAM and always-on peripherals.
 * NUM_GPIO ranges from 1 to 32; BANK_WORDS must be a power of two.
 */
module core_v_mini_mcu
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256,
  parameter int unsigned NUM_GPIO   = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                bus_req_valid_i,
  output logic                bus_req_ready_o,
  input  bus_req_t            bus_req_i,

  output logic                bus_rsp_valid_o,
  input  logic                bus_rsp_ready_i,
  output bus_rsp_t            bus_rsp_o,

  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                irq_o,

  output logic                exit_valid_o,
  output data_t               exit_value_o
);

  logic     mem_req;
  logic     ao_req;
  bus_req_t slv_req;
  data_t    mem_rdata;
  data_t    ao_rdata;

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) u_system_bus (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bus_req_valid_i(bus_req_valid_i),
    .bus_req_ready_o(bus_req_ready_o),
    .bus_req_i      (bus_req_i),
    .bus_rsp_valid_o(bus_rsp_valid_o),
    .bus_rsp_ready_i(bus_rsp_ready_i),
    .bus_rsp_o      (bus_rsp_o),
    .mem_req_o      (mem_req),
    .ao_req_o       (ao_req),
    .slv_req_o      (slv_req),
    .mem_rdata_i    (mem_rdata),
    .ao_rdata_i     (ao_rdata)
  );

  memory_subsystem #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) u_memory_subsystem (
    .clk_i        (clk_i),
    .mem_req_i    (mem_req),
    .mem_bus_req_i(slv_req),
    .mem_rdata_o  (mem_rdata)
  );

  ao_peripheral_subsystem #(
    .NUM_GPIO(NUM_GPIO)
  ) u_ao_peripheral_subsystem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ao_req_i    (ao_req),
    .ao_bus_req_i(slv_req),
    .ao_rdata_o  (ao_rdata),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .irq_o       (irq_o),
    .exit_valid_o(exit_valid_o),
    .exit_value_o(exit_value_o)
  );

endmodule

/* ao_peripheral_subsystem.sv */
/*
 * Exit, GPIO and GPIO interrupt registers; register writes ignore byte enables.
 * Inputs pass a two-flop synchronizer, so a rising edge reaches INTR_STATUS after 3 cycles.
 */
module ao_peripheral_subsystem
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_GPIO = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                ao_req_i,
  input  bus_req_t            ao_bus_req_i,
  output data_t               ao_rdata_o,

  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                irq_o,

  output logic                exit_valid_o,
  output data_t               exit_value_o
);

  addr_t               reg_ofs;
  logic                reg_wr;
  data_t               rdata_mux;

  logic                exit_valid_q;
  data_t               exit_value_q;
  logic [NUM_GPIO-1:0] gpio_out_q;
  logic [NUM_GPIO-1:0] gpio_oe_q;
  logic [NUM_GPIO-1:0] intr_status_q;
  logic [NUM_GPIO-1:0] intr_enable_q;

  logic [NUM_GPIO-1:0] gpio_meta_q;
  logic [NUM_GPIO-1:0] gpio_sync_q;
  logic [NUM_GPIO-1:0] gpio_prev_q;
  logic [NUM_GPIO-1:0] gpio_rise;
  logic [NUM_GPIO-1:0] status_clr;

  assign reg_ofs = {ao_bus_req_i.addr[31:2], 2'b00} - AO_BASE;
  assign reg_wr  = ao_req_i && ao_bus_req_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
      gpio_prev_q <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      gpio_prev_q <= gpio_sync_q;
    end
  end

  assign gpio_rise = gpio_sync_q & ~gpio_prev_q;

  // Write one to clear
  assign status_clr = (reg_wr && reg_ofs == INTR_STATUS_OFS) ?
                      ao_bus_req_i.wdata[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q  <= 1'b0;
      exit_value_q  <= '0;
      gpio_out_q    <= '0;
      gpio_oe_q     <= '0;
      intr_status_q <= '0;
      intr_enable_q <= '0;
    end else begin
      if (reg_wr) begin
        case (reg_ofs)
          EXIT_VALID_OFS:  exit_valid_q  <= ao_bus_req_i.wdata[0];
          EXIT_VALUE_OFS:  exit_value_q  <= ao_bus_req_i.wdata;
          GPIO_OUT_OFS:    gpio_out_q    <= ao_bus_req_i.wdata[NUM_GPIO-1:0];
          GPIO_OE_OFS:     gpio_oe_q     <= ao_bus_req_i.wdata[NUM_GPIO-1:0];
          INTR_ENABLE_OFS: intr_enable_q <= ao_bus_req_i.wdata[NUM_GPIO-1:0];
          default: ;
        endcase
      end
      // A new edge beats a clear in the same cycle
      intr_status_q <= (intr_status_q & ~status_clr) | gpio_rise;
    end
  end

  always_comb begin
    case (reg_ofs)
      EXIT_VALID_OFS:  rdata_mux = data_t'(exit_valid_q);
      EXIT_VALUE_OFS:  rdata_mux = exit_value_q;
      GPIO_OUT_OFS:    rdata_mux = data_t'(gpio_out_q);
      GPIO_OE_OFS:     rdata_mux = data_t'(gpio_oe_q);
      GPIO_IN_OFS:     rdata_mux = data_t'(gpio_sync_q);
      INTR_STATUS_OFS: rdata_mux = data_t'(intr_status_q);
      INTR_ENABLE_OFS: rdata_mux = data_t'(intr_enable_q);
      default:         rdata_mux = '0;
    endcase
  end

  // Held until the next read strobe
  always_ff @(posedge clk_i) begin
    if (ao_req_i && !ao_bus_req_i.we) begin
      ao_rdata_o <= rdata_mux;
    end
  end

  assign gpio_o       = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;
  assign irq_o        = |(intr_status_q & intr_enable_q);
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

/* system_bus.sv */
/*
 * Single-master bus with one outstanding access and a response one cycle after acceptance.
 * Unmapped addresses answer with err set and rdata zero; writes answer with rdata zero.
 */
module system_bus
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     bus_req_valid_i,
  output logic     bus_req_ready_o,
  input  bus_req_t bus_req_i,

  output logic     bus_rsp_valid_o,
  input  logic     bus_rsp_ready_i,
  output bus_rsp_t bus_rsp_o,

  output logic     mem_req_o,
  output logic     ao_req_o,
  output bus_req_t slv_req_o,
  input  data_t    mem_rdata_i,
  input  data_t    ao_rdata_i
);

  localparam addr_t RAM_SIZE = addr_t'(NUM_BANKS * BANK_WORDS * 4);

  logic    rsp_pending_q;
  target_e target_q;
  logic    we_q;

  target_e req_target;
  logic    accept;

  // Offsets wrap below the base, so one compare covers both bounds
  always_comb begin
    if ((bus_req_i.addr - RAM_BASE) < RAM_SIZE) begin
      req_target = TGT_RAM;
    end else if ((bus_req_i.addr - AO_BASE) < AO_SIZE) begin
      req_target = TGT_AO;
    end else begin
      req_target = TGT_NONE;
    end
  end

  // Free slot, or the pending response leaves this cycle
  assign bus_req_ready_o = !rsp_pending_q || bus_rsp_ready_i;
  assign accept          = bus_req_valid_i && bus_req_ready_o;

  assign mem_req_o = accept && (req_target == TGT_RAM);
  assign ao_req_o  = accept && (req_target == TGT_AO);
  assign slv_req_o = bus_req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_pending_q <= 1'b0;
      target_q      <= TGT_NONE;
      we_q          <= 1'b0;
    end else begin
      if (accept) begin
        rsp_pending_q <= 1'b1;
        target_q      <= req_target;
        we_q          <= bus_req_i.we;
      end else if (bus_rsp_ready_i) begin
        rsp_pending_q <= 1'b0;
      end
    end
  end

  assign bus_rsp_valid_o = rsp_pending_q;

  // Slaves hold their read data until the next strobe
  always_comb begin
    bus_rsp_o = '0;
    case (target_q)
      TGT_RAM: begin
        bus_rsp_o.rdata = we_q ? '0 : mem_rdata_i;
      end
      TGT_AO: begin
        bus_rsp_o.rdata = we_q ? '0 : ao_rdata_i;
      end
      default: begin
        bus_rsp_o.err = 1'b1;
      end
    endcase
  end

endmodule

/* memory_subsystem.sv */
/*
 * RAM made of NUM_BANKS contiguous banks; BANK_WORDS must be a power of two.
 * Read data follows one cycle after the strobe and holds until the next strobe.
 */
module memory_subsystem
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic     clk_i,
  input  logic     mem_req_i,
  input  bus_req_t mem_bus_req_i,
  output data_t    mem_rdata_o
);

  localparam int unsigned WORD_W = $clog2(BANK_WORDS);
  localparam int unsigned BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  addr_t                 ram_ofs;
  logic [WORD_W-1:0]     word_idx;
  logic [BANK_W-1:0]     bank_idx;
  logic [BANK_W-1:0]     bank_sel_q;
  logic [NUM_BANKS-1:0]  bank_req;
  data_t                 bank_rdata [NUM_BANKS];

  assign ram_ofs  = mem_bus_req_i.addr - RAM_BASE;
  assign word_idx = ram_ofs[2 +: WORD_W];
  assign bank_idx = ram_ofs[2 + WORD_W +: BANK_W];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign bank_req[b] = mem_req_i && (bank_idx == BANK_W'(b));

    sram_bank #(
      .BANK_WORDS(BANK_WORDS)
    ) u_sram_bank (
      .clk_i  (clk_i),
      .req_i  (bank_req[b]),
      .we_i   (mem_bus_req_i.we),
      .be_i   (mem_bus_req_i.be),
      .addr_i (word_idx),
      .wdata_i(mem_bus_req_i.wdata),
      .rdata_o(bank_rdata[b])
    );
  end

  // Steers the bank output that arrives next cycle
  always_ff @(posedge clk_i) begin
    if (mem_req_i) begin
      bank_sel_q <= bank_idx;
    end
  end

  assign mem_rdata_o = bank_rdata[bank_sel_q];

endmodule

/* sram_bank.sv */
/*
 * Word-wide RAM bank with byte enables and a registered read port.
 * No reset; contents and read data are undefined until written or read.
 */
module sram_bank
  import mcu_pkg::*;
#(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                          clk_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  be_t                           be_i,
  input  logic [$clog2(BANK_WORDS)-1:0] addr_i,
  input  data_t                         wdata_i,
  output data_t                         rdata_o
);

  data_t mem_q [BANK_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < $bits(be_t); i++) begin
        if (be_i[i]) begin
          mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Output only moves on a read strobe
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* mcu_pkg.sv */
/*
 * Shared bus types and address map of the MCU.
 * Peripheral offsets are byte offsets from AO_BASE and are word aligned.
 */
package mcu_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // Request from the master, 69 bits
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    be_t   be;
    logic  we;
  } bus_req_t;

  // Response to the master, 33 bits
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Decoded slave of an access
  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_AO,
    TGT_NONE
  } target_e;

  // Address map
  localparam addr_t RAM_BASE = 32'h0000_0000;
  localparam addr_t AO_BASE  = 32'h2000_0000;
  localparam addr_t AO_SIZE  = 32'h0000_1000;

  // Always-on peripheral registers
  localparam addr_t EXIT_VALID_OFS  = 32'h00;
  localparam addr_t EXIT_VALUE_OFS  = 32'h04;
  localparam addr_t GPIO_OUT_OFS    = 32'h08;
  localparam addr_t GPIO_OE_OFS     = 32'h0C;
  localparam addr_t GPIO_IN_OFS     = 32'h10;
  localparam addr_t INTR_STATUS_OFS = 32'h14;
  localparam addr_t INTR_ENABLE_OFS = 32'h18;

endpackage
